// File: flist.f
awe_row_buffers_pkg.sv
ram_port_if.sv
row_ram.sv
seq_addr_decode.sv
ce_row_buffer.sv
awe_row_buffers.sv
awe_row_buffers_assertions.sv
tb_awe_row_buffers.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator and run, the exit status carries pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f \
    --top-module tb_awe_row_buffers -o sim_tb &&
./obj_dir/sim_tb || exit 1

// File: tb_awe_row_buffers.sv
`timescale 1ns/1ps

module tb_awe_row_buffers
    import awe_row_buffers_pkg::*;
();

    localparam int NCOLS = 20;
    // About 700 cycles of stimulus, with margin
    localparam int TIMEOUT_CYCLES = 3000;

    logic                 clk = 1'b0;
    logic                 rst;
    logic [4:0]           state;
    logic [COL_W-1:0]     input_row;
    logic [COL_W-1:0]     input_col;
    logic [COL_W-1:0]     num_input_cols;
    logic [1:0]           gray_code;
    logic [SEQ_W-1:0]     seq_datain;
    logic                 pfb_rden;
    logic                 last_kernel;
    logic                 row_matric;
    logic [COL_W-1:0]     wr_addr;
    logic [PIXEL_W-1:0]   ce0_pixel_datain;
    logic [PIXEL_W-1:0]   ce1_pixel_datain;
    logic                 ce0_start;
    logic                 ce1_start;
    logic [CE_DOUT_W-1:0] ce0_pixel_dataout;
    logic [CE_DOUT_W-1:0] ce1_pixel_dataout;
    logic                 ce0_pixel_dataout_valid;
    logic                 ce1_pixel_dataout_valid;

    // Shadow RAMs per engine, plus input history for the delayed writes
    logic [PIXEL_W-1:0]   shadow_even [2][RAM_DEPTH];
    logic [PIXEL_W-1:0]   shadow_odd [2][RAM_DEPTH];
    logic [PIXEL_W-1:0]   pix_hist [2][DATAIN_DELAY];
    logic [1:0]           rm_hist;
    logic [SEQ_W-1:0]     prev_seq;
    logic [1:0]           prev_gray;
    logic [CE_DOUT_W-1:0] exp_q0 [$];
    logic [CE_DOUT_W-1:0] exp_q1 [$];
    logic [15:0]          lfsr_state = 16'd26;
    int                   cycle_count = 0;
    string                test_name = "reset";

    awe_row_buffers DUT (.*);

    bind awe_row_buffers awe_row_buffers_assertions u_assertions (
        .clk                     (clk),
        .rst                     (rst),
        .state                   (state),
        .ce0_start               (ce0_start),
        .ce1_start               (ce1_start),
        .ce0_pixel_dataout_valid (ce0_pixel_dataout_valid),
        .ce1_pixel_dataout_valid (ce1_pixel_dataout_valid)
    );

    always #5 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [COL_W-1:0] rand_col();
        logic [15:0] v;
        v = rand_bits(5);
        return COL_W'(v % 16'(NCOLS));
    endfunction

    // Odd word above even word, banks picked by gray code and half select
    function automatic logic [CE_DOUT_W-1:0] expected_word(input logic ce,
            input logic [SEQ_W-1:0] seq, input logic [1:0] gray);
        logic              half;
        logic [ADDR_W-1:0] even_a;
        logic [ADDR_W-1:0] odd_a;
        half   = seq[SEQ_HALF_BIT];
        even_a = {gray[0] ^ half, seq[COL_W-1:0]};
        odd_a  = {gray[1] ^ half, seq[COL_W-1:0]};
        return {shadow_odd[ce][odd_a], shadow_even[ce][even_a]};
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    task automatic model_engine(input logic ce);
        logic               go;
        logic               rm_d;
        logic [PIXEL_W-1:0] pix;
        logic [PIXEL_W-1:0] pix_old;
        go      = ce ? ce1_start : ce0_start;
        pix     = ce ? ce1_pixel_datain : ce0_pixel_datain;
        pix_old = pix_hist[ce][DATAIN_DELAY-1];
        rm_d    = ce ? rm_hist[CE1_ROW_MATRIC_DELAY-1] : rm_hist[CE0_ROW_MATRIC_DELAY-1];
        if (state == ST_PRIM_BUFFER && pfb_rden && input_col <= num_input_cols) begin
            if (input_row == COL_W'(0)) begin
                shadow_even[ce][{1'b0, input_col}] = pix;
                shadow_odd[ce][{1'b0, input_col}]  = pix;
            end else if (input_row == COL_W'(1)) begin
                shadow_odd[ce][{1'b1, input_col}] = pix;
            end else if (input_row == COL_W'(2)) begin
                shadow_even[ce][{1'b1, input_col}] = pix;
            end
        end
        if (state == ST_CE_ACTIVE && go) begin
            // Read sees the RAM before this cycle's write
            if (ce) begin
                exp_q1.push_back(expected_word(ce, prev_seq, prev_gray));
            end else begin
                exp_q0.push_back(expected_word(ce, seq_datain, gray_code));
            end
            if (last_kernel && rm_d) begin
                if (gray_code[0] == gray_code[1]) begin
                    shadow_odd[ce][{gray_code[0], wr_addr}] = pix_old;
                end else begin
                    shadow_even[ce][{gray_code[0], wr_addr}] = pix_old;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DATAIN_DELAY; i++) begin
                pix_hist[0][i] = '0;
                pix_hist[1][i] = '0;
            end
            rm_hist   = '0;
            prev_seq  = '0;
            prev_gray = '0;
        end else begin
            model_engine(1'b0);
            model_engine(1'b1);
            for (int i = DATAIN_DELAY - 1; i > 0; i--) begin
                pix_hist[0][i] = pix_hist[0][i-1];
                pix_hist[1][i] = pix_hist[1][i-1];
            end
            pix_hist[0][0] = ce0_pixel_datain;
            pix_hist[1][0] = ce1_pixel_datain;
            rm_hist   = {rm_hist[0], row_matric};
            prev_seq  = seq_datain;
            prev_gray = gray_code;
        end
    end

    ////////////////////
    // Compare and timeout
    ////////////////////

    task automatic check_engine(input logic ce, input logic valid,
            input logic [CE_DOUT_W-1:0] actual);
        logic [CE_DOUT_W-1:0] want;
        int                   pending;
        if (valid) begin
            pending = ce ? exp_q1.size() : exp_q0.size();
            assert (pending > 0)
                else fail_run($sformatf("ce%0d gave a valid word with no read pending", ce));
            if (ce) begin
                want = exp_q1.pop_front();
            end else begin
                want = exp_q0.pop_front();
            end
            assert (actual === want)
                else fail_run($sformatf("ERR %s ce%0d expected %h actual %h",
                                        test_name, ce, want, actual));
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            check_engine(1'b0, ce0_pixel_dataout_valid, ce0_pixel_dataout);
            check_engine(1'b1, ce1_pixel_dataout_valid, ce1_pixel_dataout);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("Run did not finish within the cycle limit");
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // Strobes drop to 0 unless the caller raises them again
    task automatic next_cycle();
        @(posedge clk);
        #1;
        ce0_pixel_datain = rand_bits(PIXEL_W);
        ce1_pixel_datain = rand_bits(PIXEL_W);
        pfb_rden    = 1'b0;
        ce0_start   = 1'b0;
        ce1_start   = 1'b0;
        last_kernel = 1'b0;
        row_matric  = 1'b0;
    endtask

    task automatic prime_row(input int row, input int first, input int last);
        for (int c = first; c <= last; c++) begin
            next_cycle();
            state     = ST_PRIM_BUFFER;
            pfb_rden  = 1'b1;
            input_row = COL_W'(row);
            input_col = COL_W'(c);
        end
    endtask

    task automatic read_word(input logic [1:0] gray, input logic half,
            input logic [COL_W-1:0] col, input logic with_row);
        logic [SEQ_W-1:0] seq;
        next_cycle();
        // Upper sequencer bits are don't care
        seq = rand_bits(SEQ_W);
        seq[SEQ_HALF_BIT] = half;
        seq[COL_W-1:0]    = col;
        state      = ST_CE_ACTIVE;
        gray_code  = gray;
        seq_datain = seq;
        ce0_start  = 1'b1;
        ce1_start  = 1'b1;
        if (with_row) begin
            last_kernel = 1'b1;
            row_matric  = next_bit();
            wr_addr     = rand_col();
        end
    endtask

    task automatic wait_drain();
        next_cycle();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            next_cycle();
        end
    endtask

    initial begin
        rst = 1'b1;
        state = ST_IDLE;
        input_row = '0;
        input_col = '0;
        num_input_cols = '0;
        gray_code = '0;
        seq_datain = '0;
        pfb_rden = 1'b0;
        last_kernel = 1'b0;
        row_matric = 1'b0;
        wr_addr = '0;
        ce0_pixel_datain = '0;
        ce1_pixel_datain = '0;
        ce0_start = 1'b0;
        ce1_start = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "reset_quiet";
        repeat (5) begin
            next_cycle();
            assert (!ce0_pixel_dataout_valid && !ce1_pixel_dataout_valid)
                else fail_run("A valid output rose before any start");
        end

        test_name = "prime";
        num_input_cols = COL_W'(NCOLS - 1);
        for (int r = 0; r < 3; r++) begin
            prime_row(r, 0, NCOLS - 1);
        end
        // Last in-range column is taken before the limit drops
        next_cycle();
        // Columns past the limit must not land
        test_name = "prime_out_of_range";
        num_input_cols = COL_W'(NCOLS - 5);
        for (int r = 0; r < 3; r++) begin
            prime_row(r, NCOLS - 4, NCOLS - 1);
        end
        next_cycle();
        state = ST_WAIT_PFB_LOAD;

        test_name = "read_gray00";
        for (int h = 0; h < 2; h++) begin
            for (int c = 0; c < NCOLS; c++) begin
                read_word(2'b00, 1'(h), COL_W'(c), 1'b0);
                next_cycle();
            end
        end
        wait_drain();

        test_name = "read_gray_swap";
        for (int h = 0; h < 2; h++) begin
            for (int c = 0; c < NCOLS; c++) begin
                read_word(2'b01, 1'(h), COL_W'(c), 1'b0);
            end
            for (int c = 0; c < NCOLS; c++) begin
                read_word(2'b11, 1'(h), COL_W'(c), 1'b0);
            end
            for (int c = 0; c < NCOLS; c++) begin
                read_word(2'b10, 1'(h), COL_W'(c), 1'b0);
            end
        end
        // Gray and half change every cycle, ce1 trails by one
        repeat (40) read_word(2'(rand_bits(2)), next_bit(), rand_col(), 1'b0);
        wait_drain();

        test_name = "incoming_rows";
        for (int g = 0; g < 4; g++) begin
            for (int c = 0; c < NCOLS; c++) begin
                read_word(2'(g), next_bit(), rand_col(), 1'b1);
            end
        end
        wait_drain();

        test_name = "read_back";
        for (int g = 0; g < 4; g++) begin
            for (int h = 0; h < 2; h++) begin
                for (int c = 0; c < NCOLS; c++) begin
                    read_word(2'(g), 1'(h), COL_W'(c), 1'b0);
                end
            end
        end
        wait_drain();

        test_name = "back_to_back";
        repeat (60) read_word(2'(rand_bits(2)), next_bit(), rand_col(), next_bit());
        wait_drain();

        next_cycle();
        state = ST_JOB_DONE;
        repeat (4) next_cycle();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: awe_row_buffers_assertions.sv
`timescale 1ns/1ps

module awe_row_buffers_assertions
    import awe_row_buffers_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic [4:0] state,
    input logic       ce0_start,
    input logic       ce1_start,
    input logic       ce0_pixel_dataout_valid,
    input logic       ce1_pixel_dataout_valid
);

    // Start to valid is three cycles
    localparam int LATENCY = 3;

    logic go0;
    logic go1;

    assign go0 = (state == ST_CE_ACTIVE) && ce0_start;
    assign go1 = (state == ST_CE_ACTIVE) && ce1_start;

    ////////////////////
    // Reset
    ////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!ce0_pixel_dataout_valid && !ce1_pixel_dataout_valid))
        else $error("valid high during reset");

    ////////////////////
    // Start and valid pairing
    ////////////////////

    a_ce0_valid_follows: assert property (@(posedge clk) disable iff (rst)
        $past(go0, LATENCY) |-> ce0_pixel_dataout_valid)
        else $error("ce0 valid missing after start");

    a_ce1_valid_follows: assert property (@(posedge clk) disable iff (rst)
        $past(go1, LATENCY) |-> ce1_pixel_dataout_valid)
        else $error("ce1 valid missing after start");

    a_ce0_no_stray_valid: assert property (@(posedge clk) disable iff (rst)
        ce0_pixel_dataout_valid |-> $past(go0, LATENCY))
        else $error("ce0 valid without a start");

    a_ce1_no_stray_valid: assert property (@(posedge clk) disable iff (rst)
        ce1_pixel_dataout_valid |-> $past(go1, LATENCY))
        else $error("ce1 valid without a start");

endmodule

// File: awe_row_buffers.sv
`timescale 1ns/1ps

module awe_row_buffers
    import awe_row_buffers_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           state,
    input  logic [COL_W-1:0]     input_row,
    input  logic [COL_W-1:0]     input_col,
    input  logic [COL_W-1:0]     num_input_cols,
    input  logic [1:0]           gray_code,
    input  logic [SEQ_W-1:0]     seq_datain,
    input  logic                 pfb_rden,
    input  logic                 last_kernel,
    input  logic                 row_matric,
    input  logic [COL_W-1:0]     wr_addr,
    input  logic [PIXEL_W-1:0]   ce0_pixel_datain,
    input  logic [PIXEL_W-1:0]   ce1_pixel_datain,
    input  logic                 ce0_start,
    input  logic                 ce1_start,
    output logic [CE_DOUT_W-1:0] ce0_pixel_dataout,
    output logic [CE_DOUT_W-1:0] ce1_pixel_dataout,
    output logic                 ce0_pixel_dataout_valid,
    output logic                 ce1_pixel_dataout_valid
);

    // Engine 0, addresses straight from the sequencer
    ce_row_buffer #(
        .ROW_MATRIC_DELAY (CE0_ROW_MATRIC_DELAY),
        .SEQ_DELAY        (0)
    ) u_ce0 (
        .clk                 (clk),
        .rst                 (rst),
        .state               (state),
        .input_row           (input_row),
        .input_col           (input_col),
        .num_input_cols      (num_input_cols),
        .wr_addr             (wr_addr),
        .gray_code           (gray_code),
        .seq_datain          (seq_datain),
        .pfb_rden            (pfb_rden),
        .last_kernel         (last_kernel),
        .row_matric          (row_matric),
        .start               (ce0_start),
        .pixel_datain        (ce0_pixel_datain),
        .pixel_dataout       (ce0_pixel_dataout),
        .pixel_dataout_valid (ce0_pixel_dataout_valid)
    );

    // Engine 1 trails by one sequencer step
    ce_row_buffer #(
        .ROW_MATRIC_DELAY (CE1_ROW_MATRIC_DELAY),
        .SEQ_DELAY        (CE1_SEQ_DELAY)
    ) u_ce1 (
        .clk                 (clk),
        .rst                 (rst),
        .state               (state),
        .input_row           (input_row),
        .input_col           (input_col),
        .num_input_cols      (num_input_cols),
        .wr_addr             (wr_addr),
        .gray_code           (gray_code),
        .seq_datain          (seq_datain),
        .pfb_rden            (pfb_rden),
        .last_kernel         (last_kernel),
        .row_matric          (row_matric),
        .start               (ce1_start),
        .pixel_datain        (ce1_pixel_datain),
        .pixel_dataout       (ce1_pixel_dataout),
        .pixel_dataout_valid (ce1_pixel_dataout_valid)
    );

endmodule

// File: ce_row_buffer.sv
`timescale 1ns/1ps

module ce_row_buffer
    import awe_row_buffers_pkg::*;
#(
    parameter int ROW_MATRIC_DELAY = 1,
    parameter int SEQ_DELAY        = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           state,
    input  logic [COL_W-1:0]     input_row,
    input  logic [COL_W-1:0]     input_col,
    input  logic [COL_W-1:0]     num_input_cols,
    input  logic [COL_W-1:0]     wr_addr,
    input  logic [1:0]           gray_code,
    input  logic [SEQ_W-1:0]     seq_datain,
    input  logic                 pfb_rden,
    input  logic                 last_kernel,
    input  logic                 row_matric,
    input  logic                 start,
    input  logic [PIXEL_W-1:0]   pixel_datain,
    output logic [CE_DOUT_W-1:0] pixel_dataout,
    output logic                 pixel_dataout_valid
);

    logic [ADDR_W-1:0]  even_rd_addr;
    logic [ADDR_W-1:0]  odd_rd_addr;
    logic [PIXEL_W-1:0] pixel_dly [DATAIN_DELAY];
    logic               matric_dly [ROW_MATRIC_DELAY];
    logic               valid_dly [VALID_DELAY];
    logic               in_range;
    logic               row_write;

    ram_port_if even_port ();
    ram_port_if odd_port ();

    seq_addr_decode #(
        .DELAY (SEQ_DELAY)
    ) u_decode (
        .clk       (clk),
        .rst       (rst),
        .gray_code (gray_code),
        .seq_word  (seq_datain),
        .even_addr (even_rd_addr),
        .odd_addr  (odd_rd_addr)
    );

    row_ram u_even_ram (
        .clk  (clk),
        .port (even_port)
    );

    row_ram u_odd_ram (
        .clk  (clk),
        .port (odd_port)
    );

    ////////////////////
    // Delay lines
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DATAIN_DELAY; i++) pixel_dly[i] <= '0;
            for (int i = 0; i < ROW_MATRIC_DELAY; i++) matric_dly[i] <= 1'b0;
            for (int i = 0; i < VALID_DELAY; i++) valid_dly[i] <= 1'b0;
        end else begin
            pixel_dly[0]  <= pixel_datain;
            matric_dly[0] <= row_matric;
            // Both RAMs are read together, the even enable stands for the pair
            valid_dly[0]  <= even_port.rd_en;
            for (int i = 1; i < DATAIN_DELAY; i++) pixel_dly[i] <= pixel_dly[i-1];
            for (int i = 1; i < ROW_MATRIC_DELAY; i++) matric_dly[i] <= matric_dly[i-1];
            for (int i = 1; i < VALID_DELAY; i++) valid_dly[i] <= valid_dly[i-1];
        end
    end

    assign in_range  = (input_col <= num_input_cols);
    assign row_write = last_kernel && matric_dly[ROW_MATRIC_DELAY-1];

    ////////////////////
    // RAM write and read control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            even_port.wr_en <= 1'b0;
            odd_port.wr_en  <= 1'b0;
            even_port.rd_en <= 1'b0;
            odd_port.rd_en  <= 1'b0;
        end else begin
            even_port.wr_en <= 1'b0;
            odd_port.wr_en  <= 1'b0;
            even_port.rd_en <= 1'b0;
            odd_port.rd_en  <= 1'b0;
            case (state)
                ST_PRIM_BUFFER: begin
                    if (pfb_rden && in_range) begin
                        // Row 0 into bank 0 of both, rows 1 and 2 into bank 1
                        if (input_row == COL_W'(0)) begin
                            even_port.wr_en   <= 1'b1;
                            even_port.wr_addr <= {1'b0, input_col};
                            even_port.wr_data <= pixel_datain;
                            odd_port.wr_en    <= 1'b1;
                            odd_port.wr_addr  <= {1'b0, input_col};
                            odd_port.wr_data  <= pixel_datain;
                        end else if (input_row == COL_W'(1)) begin
                            odd_port.wr_en    <= 1'b1;
                            odd_port.wr_addr  <= {1'b1, input_col};
                            odd_port.wr_data  <= pixel_datain;
                        end else if (input_row == COL_W'(2)) begin
                            even_port.wr_en   <= 1'b1;
                            even_port.wr_addr <= {1'b1, input_col};
                            even_port.wr_data <= pixel_datain;
                        end
                    end
                end
                ST_CE_ACTIVE: begin
                    if (start) begin
                        even_port.rd_en   <= 1'b1;
                        odd_port.rd_en    <= 1'b1;
                        even_port.rd_addr <= even_rd_addr;
                        odd_port.rd_addr  <= odd_rd_addr;
                        // Incoming row
                        if (row_write) begin
                            if (gray_code[0] == gray_code[1]) begin
                                odd_port.wr_en    <= 1'b1;
                                odd_port.wr_addr  <= {gray_code[0], wr_addr};
                                odd_port.wr_data  <= pixel_dly[DATAIN_DELAY-1];
                            end else begin
                                even_port.wr_en   <= 1'b1;
                                even_port.wr_addr <= {gray_code[0], wr_addr};
                                even_port.wr_data <= pixel_dly[DATAIN_DELAY-1];
                            end
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Output stage lines up with the valid delay
    always_ff @(posedge clk) begin
        pixel_dataout <= {odd_port.rd_data, even_port.rd_data};
    end

    assign pixel_dataout_valid = valid_dly[VALID_DELAY-1];

endmodule

// File: seq_addr_decode.sv
`timescale 1ns/1ps

module seq_addr_decode
    import awe_row_buffers_pkg::*;
#(
    parameter int DELAY = 0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [1:0]        gray_code,
    input  logic [SEQ_W-1:0]  seq_word,
    output logic [ADDR_W-1:0] even_addr,
    output logic [ADDR_W-1:0] odd_addr
);

    logic              half_sel;
    logic [COL_W-1:0]  col;
    logic [ADDR_W-1:0] even_next;
    logic [ADDR_W-1:0] odd_next;

    assign half_sel = seq_word[SEQ_HALF_BIT];
    assign col      = seq_word[COL_W-1:0];

    // Gray code swaps which bank holds the upper window row
    assign even_next = {gray_code[0] ^ half_sel, col};
    assign odd_next  = {gray_code[1] ^ half_sel, col};

    if (DELAY == 0) begin : g_comb
        assign even_addr = even_next;
        assign odd_addr  = odd_next;
    end else begin : g_reg
        // One cycle behind for the second engine
        always_ff @(posedge clk) begin
            if (rst) begin
                even_addr <= '0;
                odd_addr  <= '0;
            end else begin
                even_addr <= even_next;
                odd_addr  <= odd_next;
            end
        end
    end

endmodule

// File: row_ram.sv
`timescale 1ns/1ps

module row_ram
    import awe_row_buffers_pkg::*;
(
    input logic     clk,
    ram_port_if.ram port
);

    // One row buffer, two banks of columns
    logic [PIXEL_W-1:0] mem [RAM_DEPTH];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.wr_addr] <= port.wr_data;
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    // Same-address read during a write sees the old word
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            port.rd_data <= mem[port.rd_addr];
        end
    end

endmodule

// File: ram_port_if.sv
`timescale 1ns/1ps

interface ram_port_if
    import awe_row_buffers_pkg::*;
();

    // Write side
    logic               wr_en;
    logic [ADDR_W-1:0]  wr_addr;
    logic [PIXEL_W-1:0] wr_data;

    // Read side, data one cycle after the enable
    logic               rd_en;
    logic [ADDR_W-1:0]  rd_addr;
    logic [PIXEL_W-1:0] rd_data;

    modport ctrl (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr,
        input  rd_data
    );

    modport ram (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data
    );

endinterface

// File: awe_row_buffers_pkg.sv
package awe_row_buffers_pkg;

    ////////////////////
    // Data and memory sizes
    ////////////////////

    localparam int PIXEL_W   = 16;
    localparam int RAM_DEPTH = 512;
    // One bank bit above the column
    localparam int ADDR_W    = 9;
    localparam int COL_W     = 8;

    // Sequencer word, column in [7:0], half select in [8]
    localparam int SEQ_W        = 16;
    localparam int SEQ_HALF_BIT = 8;

    // Odd word above even word
    localparam int CE_DOUT_W = 32;

    ////////////////////
    // Pipeline delays
    ////////////////////

    // Incoming-row pixels lag the engine start
    localparam int DATAIN_DELAY = 2;
    // Valid lags the RAM read enable
    localparam int VALID_DELAY  = 2;

    // Row matric alignment per engine
    localparam int CE0_ROW_MATRIC_DELAY = 1;
    localparam int CE1_ROW_MATRIC_DELAY = 2;

    // ce1 runs one cycle behind ce0 on the read addresses
    localparam int CE1_SEQ_DELAY = 1;

    ////////////////////
    // Layer sequencer states, one-hot
    ////////////////////

    localparam logic [4:0] ST_IDLE          = 5'b00001;
    localparam logic [4:0] ST_PRIM_BUFFER   = 5'b00010;
    localparam logic [4:0] ST_WAIT_PFB_LOAD = 5'b00100;
    localparam logic [4:0] ST_CE_ACTIVE     = 5'b01000;
    localparam logic [4:0] ST_JOB_DONE      = 5'b10000;

endpackage
